// File: src/bus_mon_defs.svh
// Bus monitor constants: counter width, sync depth, register map, reset thresholds
`ifndef BUS_MON_DEFS_SVH
`define BUS_MON_DEFS_SVH

`define BUS_MON_TW          20     // Threshold and counter width
`define BUS_MON_SYNC_STAGES 2      // Flops per line synchronizer

`define BUS_MON_ADDR_CTRL    3'd0  // Enable and flag clears
`define BUS_MON_ADDR_T_FREE  3'd1  // Bus free threshold
`define BUS_MON_ADDR_T_AVAIL 3'd2  // Bus available threshold
`define BUS_MON_ADDR_T_IDLE  3'd3  // Bus idle threshold
`define BUS_MON_ADDR_STATUS  3'd4  // Read-only status

`define BUS_MON_T_FREE_RST  20'd4
`define BUS_MON_T_AVAIL_RST 20'd10
`define BUS_MON_T_IDLE_RST  20'd20

`endif

// File: src/bus_mon_pkg.sv
// Bus monitor package with line event, timing, bus condition and register write types
`include "bus_mon_defs.svh"

package bus_mon_pkg;

  // Synchronized line view plus one-cycle condition pulses
  typedef struct packed {
    logic scl;        // Synced SCL level
    logic sda;        // Synced SDA level
    logic start_det;  // SDA fall with SCL high
    logic stop_det;   // SDA rise with SCL high
    logic edge_det;   // Any change on either line
  } line_event_t;

  // Programmable thresholds, in clock cycles
  typedef struct packed {
    logic [`BUS_MON_TW-1:0] t_free;   // Free after STOP
    logic [`BUS_MON_TW-1:0] t_avail;  // Sustained free
    logic [`BUS_MON_TW-1:0] t_idle;   // Long idle
  } bus_timing_t;

  typedef struct packed {
    logic busy;   // None of the below
    logic free;
    logic avail;
    logic idle;
  } bus_cond_t;

  // CTRL register layout, enable in bit 0
  typedef struct packed {
    logic [28:0] pad;
    logic        clr_stop;   // Write one clears stop flag
    logic        clr_start;  // Write one clears start flag
    logic        en;         // Monitor enable
  } csr_ctrl_t;

  // Threshold register layout, value in low bits
  typedef struct packed {
    logic [31-`BUS_MON_TW:0] pad;
    logic [`BUS_MON_TW-1:0]  thr;
  } csr_timing_t;

  // Write word, view picked by address
  typedef union packed {
    csr_ctrl_t   ctrl;
    csr_timing_t timing;
  } csr_wdata_u;

endpackage

// File: src/bus_line_sync.sv
// Line synchronizer for SCL/SDA with registered edge, START and STOP detection
`timescale 1ns/1ps
`include "bus_mon_defs.svh"

module bus_line_sync (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,   // Raw SCL pin
  input  logic                     sda_i,   // Raw SDA pin
  output bus_mon_pkg::line_event_t line_o
);

  localparam int n_stages = `BUS_MON_SYNC_STAGES;

  logic [n_stages-1:0] scl_sync_q;  // Shift in at bit 0
  logic [n_stages-1:0] sda_sync_q;
  logic                scl_s;       // Synced levels
  logic                sda_s;
  logic                scl_prev_q;  // Levels one cycle back
  logic                sda_prev_q;
  logic                start_q;
  logic                stop_q;
  logic                edge_q;

  // Idle bus is high, so sync chain resets to ones
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_sync
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
    end else begin
      scl_sync_q <= {scl_sync_q[n_stages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[n_stages-2:0], sda_i};
    end
  end

  assign scl_s = scl_sync_q[n_stages-1];
  assign sda_s = sda_sync_q[n_stages-1];

  // Third edge: compare with previous levels, register pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_edge
    if (!rst_ni) begin
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
      edge_q     <= 1'b0;
    end else begin
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      start_q    <= scl_s & scl_prev_q & sda_prev_q & ~sda_s;  // SDA fall, SCL held high
      stop_q     <= scl_s & scl_prev_q & ~sda_prev_q & sda_s;  // SDA rise, SCL held high
      edge_q     <= (scl_s ^ scl_prev_q) | (sda_s ^ sda_prev_q);
    end
  end

  // Levels taken from prev regs so they line up with the pulses
  assign line_o.scl       = scl_prev_q;
  assign line_o.sda       = sda_prev_q;
  assign line_o.start_det = start_q;
  assign line_o.stop_det  = stop_q;
  assign line_o.edge_det  = edge_q;

endmodule

// File: src/bus_timers.sv
// Bus condition timer counting quiet-bus cycles against free, available and idle thresholds
`timescale 1ns/1ps
`include "bus_mon_defs.svh"

module bus_timers (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,           // Quiet bus, monitor on
  input  logic                     restart_counter_i,  // Any line edge
  input  bus_mon_pkg::bus_timing_t timing_i,
  output bus_mon_pkg::bus_cond_t   cond_o
);

  logic [`BUS_MON_TW-1:0] count_q;   // Cycles of sustained quiet
  logic                   enable_q;
  logic                   free;
  logic                   avail;
  logic                   idle;

  // Registered enable; idle stops the count so it cannot wrap
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_enable
    if (!rst_ni) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= enable_i & ~idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_count
    if (!rst_ni) begin
      count_q <= '0;
    end else if (restart_counter_i) begin
      count_q <= '0;                // Restart wins over counting
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Available is timed from start of the quiet period, not the STOP edge.
  // That only ever reports it late, which is the safe side for the bus.
  assign free  = (count_q >= timing_i.t_free);
  assign avail = (count_q >= timing_i.t_avail);
  assign idle  = (count_q >= timing_i.t_idle);

  assign cond_o.free  = free;
  assign cond_o.avail = avail;
  assign cond_o.idle  = idle;
  assign cond_o.busy  = ~(free | avail | idle);  // Busy until first threshold

endmodule

// File: src/bus_mon_ctrl.sv
// Bus monitor control: transfer tracking, timer gating and sticky START/STOP flags
`timescale 1ns/1ps

module bus_mon_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  bus_mon_pkg::line_event_t line_i,
  input  logic                     mon_en_i,      // From CTRL register
  input  logic                     clr_start_i,   // Write-one-clear pulses
  input  logic                     clr_stop_i,
  input  bus_mon_pkg::bus_cond_t   cond_i,        // Raw timer result
  output logic                     count_en_o,
  output logic                     restart_o,
  output logic                     start_seen_o,
  output logic                     stop_seen_o,
  output bus_mon_pkg::bus_cond_t   cond_o         // Published condition
);

  logic xfer_open_q;   // Between START and STOP
  logic start_seen_q;
  logic stop_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_xfer
    if (!rst_ni) begin
      xfer_open_q <= 1'b0;
    end else if (line_i.start_det) begin
      xfer_open_q <= 1'b1;          // Also covers repeated START
    end else if (line_i.stop_det) begin
      xfer_open_q <= 1'b0;
    end
  end

  // Sticky flags, a new event beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_sticky
    if (!rst_ni) begin
      start_seen_q <= 1'b0;
      stop_seen_q  <= 1'b0;
    end else begin
      if (line_i.start_det) begin
        start_seen_q <= 1'b1;
      end else if (clr_start_i) begin
        start_seen_q <= 1'b0;
      end
      if (line_i.stop_det) begin
        stop_seen_q <= 1'b1;
      end else if (clr_stop_i) begin
        stop_seen_q <= 1'b0;
      end
    end
  end

  assign start_seen_o = start_seen_q;
  assign stop_seen_o  = stop_seen_q;

  // Count only with both lines high and no transfer open
  assign count_en_o = mon_en_i & ~xfer_open_q & line_i.scl & line_i.sda;
  assign restart_o  = line_i.edge_det;  // Any edge means bus activity

  // Open transfer forces busy and masks the timer flags
  always_comb begin
    cond_o = cond_i;
    if (xfer_open_q) begin
      cond_o.busy  = 1'b1;
      cond_o.free  = 1'b0;
      cond_o.avail = 1'b0;
      cond_o.idle  = 1'b0;
    end
  end

endmodule

// File: src/bus_mon_csr.sv
// Bus monitor registers: enable, thresholds, flag clears and registered read data
`timescale 1ns/1ps
`include "bus_mon_defs.svh"

module bus_mon_csr (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     csr_we_i,
  input  logic                     csr_re_i,
  input  logic [2:0]               csr_addr_i,
  input  bus_mon_pkg::csr_wdata_u  csr_wdata_i,
  output logic [31:0]              csr_rdata_o,   // Valid cycle after csr_re_i
  input  logic                     start_seen_i,
  input  logic                     stop_seen_i,
  input  bus_mon_pkg::bus_cond_t   cond_i,
  output logic                     mon_en_o,
  output logic                     clr_start_o,
  output logic                     clr_stop_o,
  output bus_mon_pkg::bus_timing_t timing_o
);

  localparam int pad_w = 32 - `BUS_MON_TW;  // Zero fill on threshold reads

  bus_mon_pkg::bus_timing_t timing_q;
  logic                     mon_en_q;
  logic                     clr_start_q;  // One-cycle clear pulses
  logic                     clr_stop_q;
  logic                     wr_ctrl;
  logic [31:0]              rdata_d;
  logic [31:0]              rdata_q;

  assign wr_ctrl = csr_we_i & (csr_addr_i == `BUS_MON_ADDR_CTRL);

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_write
    if (!rst_ni) begin
      mon_en_q         <= 1'b0;
      clr_start_q      <= 1'b0;
      clr_stop_q       <= 1'b0;
      timing_q.t_free  <= `BUS_MON_T_FREE_RST;
      timing_q.t_avail <= `BUS_MON_T_AVAIL_RST;
      timing_q.t_idle  <= `BUS_MON_T_IDLE_RST;
    end else begin
      clr_start_q <= wr_ctrl & csr_wdata_i.ctrl.clr_start;
      clr_stop_q  <= wr_ctrl & csr_wdata_i.ctrl.clr_stop;
      if (csr_we_i) begin
        case (csr_addr_i)
          `BUS_MON_ADDR_CTRL:    mon_en_q         <= csr_wdata_i.ctrl.en;
          `BUS_MON_ADDR_T_FREE:  timing_q.t_free  <= csr_wdata_i.timing.thr;
          `BUS_MON_ADDR_T_AVAIL: timing_q.t_avail <= csr_wdata_i.timing.thr;
          `BUS_MON_ADDR_T_IDLE:  timing_q.t_idle  <= csr_wdata_i.timing.thr;
          default: ;                                  // STATUS is read-only
        endcase
      end
    end
  end

  // STATUS bits: 0 busy, 1 free, 2 avail, 3 idle, 4 start_seen, 5 stop_seen
  always_comb begin
    case (csr_addr_i)
      `BUS_MON_ADDR_CTRL:    rdata_d = {31'b0, mon_en_q};
      `BUS_MON_ADDR_T_FREE:  rdata_d = {{pad_w{1'b0}}, timing_q.t_free};
      `BUS_MON_ADDR_T_AVAIL: rdata_d = {{pad_w{1'b0}}, timing_q.t_avail};
      `BUS_MON_ADDR_T_IDLE:  rdata_d = {{pad_w{1'b0}}, timing_q.t_idle};
      `BUS_MON_ADDR_STATUS:  rdata_d = {26'b0, stop_seen_i, start_seen_i,
                                        cond_i.idle, cond_i.avail, cond_i.free, cond_i.busy};
      default:               rdata_d = 32'b0;  // Unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rdata_q <= 32'b0;
    end else if (csr_re_i) begin
      rdata_q <= rdata_d;  // Held until next read
    end
  end

  assign csr_rdata_o = rdata_q;
  assign mon_en_o    = mon_en_q;
  assign clr_start_o = clr_start_q;
  assign clr_stop_o  = clr_stop_q;
  assign timing_o    = timing_q;

endmodule

// File: src/bus_mon_top.sv
// Bus condition monitor top level joining line sync, control, timers and registers
`timescale 1ns/1ps

module bus_mon_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic                   csr_we_i,
  input  logic                   csr_re_i,
  input  logic [2:0]             csr_addr_i,
  input  logic [31:0]            csr_wdata_i,
  output logic [31:0]            csr_rdata_o,
  output bus_mon_pkg::bus_cond_t bus_cond_o
);

  bus_mon_pkg::line_event_t line;         // Sync to ctrl
  bus_mon_pkg::bus_timing_t timing;       // CSR to timers
  bus_mon_pkg::bus_cond_t   raw_cond;     // Timers to ctrl
  bus_mon_pkg::csr_wdata_u  wdata_u;
  logic                     mon_en;
  logic                     clr_start;
  logic                     clr_stop;
  logic                     count_en;
  logic                     restart;
  logic                     start_seen;
  logic                     stop_seen;

  assign wdata_u = csr_wdata_i;  // Reinterpret as register write word

  bus_line_sync u_line_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .line_o (line)
  );

  bus_mon_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .line_i       (line),
    .mon_en_i     (mon_en),
    .clr_start_i  (clr_start),
    .clr_stop_i   (clr_stop),
    .cond_i       (raw_cond),
    .count_en_o   (count_en),
    .restart_o    (restart),
    .start_seen_o (start_seen),
    .stop_seen_o  (stop_seen),
    .cond_o       (bus_cond_o)
  );

  bus_timers u_timers (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .enable_i          (count_en),
    .restart_counter_i (restart),
    .timing_i          (timing),
    .cond_o            (raw_cond)
  );

  bus_mon_csr u_csr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_re_i     (csr_re_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (wdata_u),
    .csr_rdata_o  (csr_rdata_o),
    .start_seen_i (start_seen),
    .stop_seen_i  (stop_seen),
    .cond_i       (bus_cond_o),   // Masked view for STATUS
    .mon_en_o     (mon_en),
    .clr_start_o  (clr_start),
    .clr_stop_o   (clr_stop),
    .timing_o     (timing)
  );

endmodule

// File: verif/tb_bus_mon.sv
// Testbench for the bus condition monitor with pin stimulus, register accesses and timing checks
`timescale 1ns/1ps
`include "bus_mon_defs.svh"

module tb_bus_mon;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   scl;
  logic                   sda;
  logic                   csr_we;
  logic                   csr_re;
  logic [2:0]             csr_addr;
  logic [31:0]            csr_wdata;
  logic [31:0]            csr_rdata;
  bus_mon_pkg::bus_cond_t bus_cond;
  logic [3:0]             cond_bits;   // busy, free, avail, idle from bit 3 down

  int          n_checks;
  int          n_errors;
  int          seed;
  logic [31:0] rd;
  int          thr [3];                // Free, avail, idle thresholds
  int          t_seen [3];             // Cycle each condition first showed
  string       thr_name [3];
  logic [1:0]  pins_q = 2'b11;         // Pin levels at the last rising edge
  int          quiet_cyc;              // Rising edges since a pin last changed

  bus_mon_top DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .scl_i       (scl),
    .sda_i       (sda),
    .csr_we_i    (csr_we),
    .csr_re_i    (csr_re),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .bus_cond_o  (bus_cond)
  );

  assign cond_bits = bus_cond;

  always #10 clk_i = ~clk_i;  // 20 ns period

  always @(posedge clk_i) begin
    pins_q <= {scl, sda};
    if ({scl, sda} != pins_q) begin
      quiet_cyc <= 0;
    end else if (quiet_cyc < 1000) begin
      quiet_cyc <= quiet_cyc + 1;
    end
  end

  // Free, avail and idle only fall shortly after a pin change
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($fell(bus_cond.free) || $fell(bus_cond.avail) || $fell(bus_cond.idle))
      |-> quiet_cyc <= 5)
  else begin
    n_errors++;
    $display("Bus condition dropped %0d cycles after the last pin change", quiet_cyc);
  end

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_window(input string what, input int cyc, input int lo, input int hi);
    n_checks++;
    assert (cyc >= lo && cyc <= hi) else begin
      n_errors++;
      $display("%s showed after %0d cycles, outside %0d to %0d", what, cyc, lo, hi);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timed out waiting for %s", what);
  endtask

  // Called on a falling edge and leaves one spare cycle for clear pulses
  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk_i);
    csr_we = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    csr_re   = 1'b1;
    csr_addr = addr;
    @(negedge clk_i);
    csr_re = 1'b0;
    data   = csr_rdata;   // One cycle after the strobe
  endtask

  task automatic idle_cycles(input int cyc);
    repeat (cyc) @(negedge clk_i);
  endtask

  // Waits for one condition bit to reach a level within limit cycles
  task automatic wait_flag(input int idx, input logic lvl, input int limit,
                           input string what);
    int cyc;
    cyc = 0;
    while (cond_bits[idx] !== lvl && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (cond_bits[idx] !== lvl) report_timeout(what);
  endtask

  // From SCL low drive data low and SCL high, then the SDA rise marks STOP
  task automatic send_stop();
    sda = 1'b0;
    idle_cycles(2);
    scl = 1'b1;
    idle_cycles(3);
    sda = 1'b1;
  endtask

  // Records when free, avail and idle first show and checks that they hold
  task automatic time_conditions(input int limit);
    logic [2:0] up;
    int         cyc;
    int         k;
    up  = 3'b000;
    cyc = 0;
    while (up != 3'b111 && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
      for (k = 0; k < 3; k++) begin
        if (cond_bits[2-k]) begin
          if (!up[k]) t_seen[k] = cyc;
          up[k] = 1'b1;
        end else if (up[k]) begin
          n_errors++;
          $display("Condition %0d dropped after asserting, cycle %0d", k, cyc);
        end
      end
    end
    if (up != 3'b111) report_timeout("free, avail and idle");
    for (k = 0; k < 3; k++) begin
      check_window(thr_name[k], t_seen[k], thr[k], thr[k] + 6);
    end
    for (k = 0; k < 5; k++) begin
      @(negedge clk_i);
      expect_value("bus_cond_o", {28'b0, cond_bits}, 32'h7);  // Held and not busy
    end
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    scl       = 1'b1;
    sda       = 1'b1;
    csr_we    = 1'b0;
    csr_re    = 1'b0;
    csr_addr  = 3'd0;
    csr_wdata = 32'b0;
    n_checks  = 0;
    n_errors  = 0;
    seed      = 32'h64f7e1da;
    thr_name[0] = "free";
    thr_name[1] = "avail";
    thr_name[2] = "idle";
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state
    expect_value("bus_cond_o", {28'b0, cond_bits}, 32'h8);
    read_reg(`BUS_MON_ADDR_T_FREE, rd);
    expect_value("t_free", rd, {12'b0, `BUS_MON_T_FREE_RST});
    read_reg(`BUS_MON_ADDR_T_AVAIL, rd);
    expect_value("t_avail", rd, {12'b0, `BUS_MON_T_AVAIL_RST});
    read_reg(`BUS_MON_ADDR_T_IDLE, rd);
    expect_value("t_idle", rd, {12'b0, `BUS_MON_T_IDLE_RST});
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h01);

    // Ordered random thresholds in 2 to 40 written and read back
    thr[0] = 2 + ($unsigned($random(seed)) % 13);
    thr[1] = thr[0] + 1 + ($unsigned($random(seed)) % 13);
    thr[2] = thr[1] + 1 + ($unsigned($random(seed)) % 13);
    for (int k = 0; k < 3; k++) begin
      write_reg(3'(k + 1), 32'(thr[k]));
      read_reg(3'(k + 1), rd);
      expect_value(thr_name[k], rd, 32'(thr[k]));
      csr_addr = `BUS_MON_ADDR_STATUS;  // Other address with no strobe
      @(negedge clk_i);
      expect_value("csr_rdata_o", csr_rdata, 32'(thr[k]));  // Held after the read
    end
    write_reg(`BUS_MON_ADDR_CTRL, 32'h1);
    wait_flag(2, 1'b1, thr[0] + 10, "free after enable");

    // START masks the free bus and sets the sticky flag
    sda = 1'b0;
    wait_flag(3, 1'b1, 5, "busy after START");
    expect_value("bus_cond_o", {28'b0, cond_bits}, 32'h8);
    scl = 1'b0;
    idle_cycles(3);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h11);
    write_reg(`BUS_MON_ADDR_CTRL, 32'h3);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h01);

    // STOP then quiet bus with free, avail and idle in their windows
    send_stop();
    time_conditions(thr[2] + 20);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h2E);

    // SCL pulse on a free bus restarts timing from the rising edge
    scl = 1'b0;
    wait_flag(2, 1'b0, 5, "free to drop after SCL pulse");
    expect_value("bus_cond_o", {28'b0, cond_bits}, 32'h8);
    scl = 1'b1;
    time_conditions(thr[2] + 20);
    write_reg(`BUS_MON_ADDR_CTRL, 32'h5);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h0E);

    // Monitor off keeps the bus busy after STOP while flags still record
    write_reg(`BUS_MON_ADDR_CTRL, 32'h0);
    sda = 1'b0;
    wait_flag(3, 1'b1, 5, "busy after START");
    scl = 1'b0;
    idle_cycles(3);
    send_stop();
    for (int k = 0; k < thr[2] + 10; k++) begin
      @(negedge clk_i);
      expect_value("bus_cond_o", {28'b0, cond_bits}, 32'h8);
    end
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h31);
    write_reg(`BUS_MON_ADDR_CTRL, 32'h4);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h11);
    write_reg(`BUS_MON_ADDR_CTRL, 32'h2);
    read_reg(`BUS_MON_ADDR_STATUS, rd);
    expect_value("status", rd, 32'h01);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/bus_mon_pkg.sv
src/bus_line_sync.sv
src/bus_timers.sv
src/bus_mon_ctrl.sv
src/bus_mon_csr.sv
src/bus_mon_top.sv
verif/tb_bus_mon.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bus monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_bus_mon -o tb_bus_mon
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_bus_mon)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
